/* verif/bus_arb_stimulus.txt */
# batch master bid addr write wdata, all hex; lines of one batch request together
# a master listed twice in a batch requests again right after its first done
00 0 0a FFEF0010 1 11110000
00 1 32 FFEF1010 1 22221111
00 2 1e FFEF2010 1 33332222
00 3 32 FFEF3010 1 44443333
01 0 28 FFEF0010 0 0
01 1 14 FFEF1010 0 0
01 2 23 FFEF2010 0 0
01 3 05 FFEF3010 0 0
02 0 5a FFEF0020 1 a0a00002
02 1 14 FFEF1020 0 0
03 0 5a FFEF0020 0 0
03 1 14 FFEF1024 1 b1b10003
04 0 5a FFEF0024 1 a0a00004
04 1 14 FFEF1024 0 0
05 0 5a FFEF0024 0 0
05 1 14 FFEF3010 0 0
06 0 5a FFEF0028 0 0
06 1 14 FFEF1028 1 b1b10006
07 1 1e FFEF2040 1 c0c00001
07 1 1e FFEF2044 1 c0c00002
07 1 1e FFEF2048 1 c0c00003
07 1 1e FFEF204c 1 c0c00004
07 3 05 FFEF2040 0 0
08 1 ff FFEF2044 0 0
08 2 ff FFEF2048 0 0
09 0 0a 12340000 0 0
09 2 0a FFEF5000 0 0
09 3 0a FFEF204c 0 0

/* files.f */
common/bus_arb_pkg.sv
arbiter/credit_ledger.sv
arbiter/bid_select.sv
apb/apb_bridge.sv
src/bus_arb_top.sv
verif/bus_arb_asserts.sv
verif/bus_arb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the arbiter testbench with Verilator, then look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module bus_arb_tb \
    -o bus_arb_sim > build.log 2>&1 \
    && ./obj_dir/bus_arb_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }
grep -q "^=== PASS ===$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* verif/bus_arb_tb.sv */
// Testbench for the credit-based bus arbiter. Reads request batches from a stimulus file,
// predicts grant order, read data and errors with a reference model, and checks the DUT.
`timescale 1ns/100ps
`default_nettype none

module bus_arb_tb;

    localparam int max_lines = 64;
    localparam int nm        = bus_arb_pkg::num_masters;

    logic                 bm0, rst_n;
    logic [nm-1:0]        req, write, grant, done;
    logic [3:0]           pready, psel;
    bus_arb_pkg::bid_t    bid [nm];
    bus_arb_pkg::addr_t   addr [nm];
    bus_arb_pkg::data_t   wdata [nm];
    bus_arb_pkg::data_t   prdata [4];
    bus_arb_pkg::data_t   rdata, pwdata;
    bus_arb_pkg::addr_t   paddr;
    logic                 err, penable, pwrite;

    int                   s_batch [max_lines];   // Stimulus columns, one entry per line
    int                   s_master [max_lines];
    int                   s_bid [max_lines];
    logic [31:0]          s_addr [max_lines];
    int                   s_write [max_lines];
    logic [31:0]          s_wdata [max_lines];
    int                   n_lines;
    int                   q_idx [nm][16];        // Pending stimulus lines per master
    int                   q_head [nm];
    int                   q_tail [nm];
    int                   m_bal [nm];            // Model balances and wait counts
    int                   m_wait [nm];
    int                   m_xfers;
    bus_arb_pkg::data_t   mem [4][256];          // Slave memories
    bus_arb_pkg::data_t   ref_mem [4][256];
    logic                 saw_psel;
    int                   errors, checks;

    bus_arb_top dut_i (
        .bm0(bm0), .rst_n(rst_n), .req(req), .bid(bid), .addr(addr), .write(write),
        .wdata(wdata), .prdata(prdata), .pready(pready), .grant(grant), .done(done),
        .rdata(rdata), .err(err), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata)
    );

    initial
    begin
        bm0 = 1'b0;
        forever #4 bm0 = ~bm0;
    end

    always_comb
    begin
        for (int s = 0; s < 4; s++)
        begin
            prdata[s] = mem[s][paddr[9:2]];
        end
    end

    always @(posedge bm0)
    begin
        if (|psel)
        begin
            saw_psel = 1'b1;
        end
        for (int s = 0; s < 4; s++)
        begin
            if (psel[s] && penable && pready[s] && pwrite)
            begin
                mem[s][paddr[9:2]] = pwdata;
            end
        end
    end

    // Random wait states on every slave
    always @(negedge bm0)
    begin
        for (int s = 0; s < 4; s++)
        begin
            pready[s] = ($urandom % 3) != 0;
        end
    end

    function automatic bus_arb_pkg::data_t fill_word(input int s, input int w);
        return 32'hC300_0000 | (s << 12) | (w << 2) | ((s * 7 + w) << 20);
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    got;
        int    b, m, bd, w;
        logic [31:0] a, d;
        string line;
        fd = $fopen("verif/bus_arb_stimulus.txt", "r");
        n_lines = 0;
        if (fd == 0)
        begin
            $display("Could not open the stimulus file");
        end
        else
        begin
            while (!$feof(fd) && n_lines < max_lines)
            begin
                got = $fgets(line, fd);
                if (got > 0 && line.len() > 0 && line[0] != "#" &&
                    $sscanf(line, "%h %h %h %h %h %h", b, m, bd, a, w, d) == 6)
                begin
                    s_batch[n_lines]  = b;
                    s_master[n_lines] = m;
                    s_bid[n_lines]    = bd;
                    s_addr[n_lines]   = a;
                    s_write[n_lines]  = w;
                    s_wdata[n_lines]  = d;
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic logic pending(input int m);
        return q_head[m] < q_tail[m];
    endfunction

    task automatic drive_head(input int m);
        int k;
        if (pending(m))
        begin
            k = q_idx[m][q_head[m]];
            req[m]   = 1'b1;
            bid[m]   = bus_arb_pkg::bid_t'(s_bid[k]);
            addr[m]  = s_addr[k];
            write[m] = s_write[k] != 0;
            wdata[m] = s_wdata[k];
        end
        else
        begin
            req[m] = 1'b0;
        end
    endtask

    // Starved requester first, then the highest affordable bid, then a free ride
    task automatic model_pick(output int w, output int d);
        int b;
        w = -1;
        d = 0;
        for (int i = 0; i < nm; i++)
        begin
            if (w < 0 && pending(i) && m_wait[i] >= int'(bus_arb_pkg::starve_limit))
            begin
                w = i;
                d = s_bid[q_idx[i][q_head[i]]];
            end
        end
        if (w < 0)
        begin
            for (int i = 0; i < nm; i++)
            begin
                b = pending(i) ? s_bid[q_idx[i][q_head[i]]] : 0;
                if (pending(i) && m_bal[i] >= b && (w < 0 || b > d))
                begin
                    w = i;
                    d = b;
                end
            end
        end
        if (w < 0)
        begin
            for (int i = nm - 1; i >= 0; i--)
            begin
                if (pending(i))
                begin
                    w = i;
                end
            end
            d = 0;
        end
        m_bal[w] = (m_bal[w] > d) ? m_bal[w] - d : 0;
        for (int i = 0; i < nm; i++)
        begin
            if (i != w && pending(i) && m_wait[i] < 7)
            begin
                m_wait[i]++;
            end
        end
        m_wait[w] = 0;
    endtask

    task automatic finish_transfer();
        int   w, d, k, s;
        logic ok;
        model_pick(w, d);
        k  = q_idx[w][q_head[w]];
        s  = s_addr[k][15:12];
        ok = (s_addr[k][31:16] == bus_arb_pkg::region_base) && (s < bus_arb_pkg::num_slaves);
        check(done, 32'(1 << w), "done vector");
        check(grant, 32'(1 << w), "grant vector");
        check(err, !ok, "err flag");
        check(saw_psel, ok, "psel activity");
        if (!ok)
        begin
            check(rdata, 0, "rdata on error");
        end
        else if (s_write[k] != 0)
        begin
            ref_mem[s][s_addr[k][9:2]] = s_wdata[k];
        end
        else
        begin
            check(rdata, ref_mem[s][s_addr[k][9:2]], "read data");
        end
        m_xfers++;
        if (m_xfers % int'(bus_arb_pkg::refill_every) == 0)
        begin
            for (int i = 0; i < nm; i++)
            begin
                m_bal[i] = (m_bal[i] + 40 > 200) ? 200 : m_bal[i] + 40;
            end
        end
        saw_psel = 1'b0;
        q_head[w]++;
        drive_head(w);   // Next request of the same master, or req low
    endtask

    initial
    begin
        int idx, cur, busy_any;
        void'($urandom(20736));
        rst_n = 1'b0;
        req = '0;
        write = '0;
        pready = '0;
        saw_psel = 1'b0;
        errors = 0;
        checks = 0;
        m_xfers = 0;
        for (int i = 0; i < nm; i++)
        begin
            bid[i] = '0;
            addr[i] = '0;
            wdata[i] = '0;
            m_bal[i] = int'(bus_arb_pkg::balance_max);
            m_wait[i] = 0;
        end
        for (int s = 0; s < 4; s++)
        begin
            for (int w = 0; w < 256; w++)
            begin
                mem[s][w] = fill_word(s, w);
                ref_mem[s][w] = fill_word(s, w);
            end
        end
        load_stimulus();
        repeat (5) @(posedge bm0);
        @(negedge bm0) rst_n = 1'b1;
        idx = 0;
        while (idx < n_lines)
        begin
            cur = s_batch[idx];
            for (int i = 0; i < nm; i++)
            begin
                q_head[i] = 0;
                q_tail[i] = 0;
            end
            while (idx < n_lines && s_batch[idx] == cur)
            begin
                q_idx[s_master[idx]][q_tail[s_master[idx]]] = idx;
                q_tail[s_master[idx]]++;
                idx++;
            end
            @(negedge bm0);
            for (int i = 0; i < nm; i++)
            begin
                drive_head(i);   // Whole batch raises its requests together
            end
            busy_any = 1;
            while (busy_any != 0)
            begin
                @(negedge bm0);
                if (|done)
                begin
                    finish_transfer();
                end
                busy_any = 0;
                for (int i = 0; i < nm; i++)
                begin
                    busy_any += pending(i);
                end
            end
        end
        if (n_lines == 0)
        begin
            $display("No stimulus lines were read, so nothing was tested");
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog sized from the number of transfers and a generous per-transfer bound
    initial
    begin
        @(posedge rst_n);
        #(n_lines * 60 * 8 + 400);
        $display("Timeout: transfers did not complete in the expected time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule : bus_arb_tb

`default_nettype wire

/* verif/bus_arb_asserts.sv */
// Concurrent checks on one-hot selects and APB phase rules.
// Bound into the APB bridge and the bid selector.
`timescale 1ns/100ps
`default_nettype none

module bus_arb_asserts (
    input wire logic               bm0,
    input wire logic               rst_n,
    input wire logic [3:0]         sel_vec,   // psel or grant
    input wire logic               penable,   // penable, or busy on the selector
    input wire logic [3:0]         psel,
    input wire bus_arb_pkg::addr_t paddr,
    input wire logic               pwrite,
    input wire logic               ready      // pready of the selected slave
);

    sel_onehot: assert property (@(posedge bm0) disable iff (!rst_n) $onehot0(sel_vec))
        else $error("Select vector has more than one bit set");

    enable_needs_sel: assert property (@(posedge bm0) disable iff (!rst_n) penable |-> (|psel))
        else $error("Enable high with an empty select vector");

    // A waiting phase must not move the held values
    hold_while_wait: assert property (@(posedge bm0) disable iff (!rst_n)
        penable && !ready |=> $stable(paddr) && $stable(pwrite))
        else $error("Held address or direction changed while waiting");

endmodule : bus_arb_asserts

bind apb_bridge bus_arb_asserts apb_chk (
    .bm0(bm0), .rst_n(rst_n), .sel_vec(psel), .penable(penable), .psel(psel),
    .paddr(paddr), .pwrite(pwrite), .ready(pready_sel)
);

// The selector must hold exactly one grant for as long as the bridge is busy
bind bid_select bus_arb_asserts grant_chk (
    .bm0(bm0), .rst_n(rst_n), .sel_vec(grant), .penable(busy), .psel(grant),
    .paddr(bus_arb_pkg::addr_t'(grant)), .pwrite(1'b0), .ready(1'b0)
);

`default_nettype wire

/* src/bus_arb_top.sv */
// Top level of the credit-based bus arbiter with an APB slave side.
// Connects the credit ledger, the bid selector and the APB bridge.
`timescale 1ns/100ps
`default_nettype none

module bus_arb_top (
    input  wire logic                                bm0,
    input  wire logic                                rst_n,
    input  wire logic [bus_arb_pkg::num_masters-1:0] req,
    input  wire bus_arb_pkg::bid_t                   bid    [bus_arb_pkg::num_masters],
    input  wire bus_arb_pkg::addr_t                  addr   [bus_arb_pkg::num_masters],
    input  wire logic [bus_arb_pkg::num_masters-1:0] write,
    input  wire bus_arb_pkg::data_t                  wdata  [bus_arb_pkg::num_masters],
    input  wire bus_arb_pkg::data_t                  prdata [bus_arb_pkg::num_slaves],
    input  wire logic [bus_arb_pkg::num_slaves-1:0]  pready,
    output logic [bus_arb_pkg::num_masters-1:0]      grant,
    output logic [bus_arb_pkg::num_masters-1:0]      done,
    output bus_arb_pkg::data_t                       rdata,
    output logic                                     err,
    output logic [bus_arb_pkg::num_slaves-1:0]       psel,
    output logic                                     penable,
    output logic                                     pwrite,
    output bus_arb_pkg::addr_t                       paddr,
    output bus_arb_pkg::data_t                       pwdata
);

    logic                     pick;
    bus_arb_pkg::master_idx_t winner;
    bus_arb_pkg::bid_t        debit;
    bus_arb_pkg::bid_t        balance [bus_arb_pkg::num_masters];
    logic                     start;
    bus_arb_pkg::addr_t       start_addr;
    logic                     start_write;
    bus_arb_pkg::data_t       start_wdata;
    logic                     busy;
    logic                     xfer_done;

    credit_ledger u_ledger (
        .bm0       (bm0),
        .rst_n     (rst_n),
        .pick      (pick),
        .winner    (winner),
        .debit     (debit),
        .xfer_done (xfer_done),
        .balance   (balance)
    );

    bid_select u_select (
        .bm0         (bm0),
        .rst_n       (rst_n),
        .req         (req),
        .bid         (bid),
        .addr        (addr),
        .write       (write),
        .wdata       (wdata),
        .balance     (balance),
        .busy        (busy),
        .pick        (pick),
        .winner      (winner),
        .debit       (debit),
        .grant       (grant),
        .start       (start),
        .start_addr  (start_addr),
        .start_write (start_write),
        .start_wdata (start_wdata)
    );

    apb_bridge u_bridge (
        .bm0         (bm0),
        .rst_n       (rst_n),
        .start       (start),
        .start_addr  (start_addr),
        .start_write (start_write),
        .start_wdata (start_wdata),
        .winner      (winner),
        .prdata      (prdata),
        .pready      (pready),
        .busy        (busy),
        .done        (done),
        .rdata       (rdata),
        .err         (err),
        .xfer_done   (xfer_done),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata)
    );

endmodule : bus_arb_top

`default_nettype wire

/* apb/apb_bridge.sv */
// Transfer stage. Decodes the winner's address and runs one APB transfer to the
// selected slave, or declines an unmapped address with an error.
`timescale 1ns/100ps
`default_nettype none

module apb_bridge (
    input  wire logic                                bm0,
    input  wire logic                                rst_n,
    input  wire logic                                start,
    input  wire bus_arb_pkg::addr_t                  start_addr,
    input  wire logic                                start_write,
    input  wire bus_arb_pkg::data_t                  start_wdata,
    input  wire bus_arb_pkg::master_idx_t            winner,
    input  wire bus_arb_pkg::data_t                  prdata [bus_arb_pkg::num_slaves],
    input  wire logic [bus_arb_pkg::num_slaves-1:0]  pready,
    output logic                                     busy,
    output logic [bus_arb_pkg::num_masters-1:0]      done,
    output bus_arb_pkg::data_t                       rdata,
    output logic                                     err,
    output logic                                     xfer_done,
    output logic [bus_arb_pkg::num_slaves-1:0]       psel,
    output logic                                     penable,
    output logic                                     pwrite,
    output bus_arb_pkg::addr_t                       paddr,
    output bus_arb_pkg::data_t                       pwdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_setup,
        st_access,
        st_decline,     // Unmapped address, no bus cycle
        st_done,
        st_fail         // Done with error
    } state_t;

    state_t                                 state;
    bus_arb_pkg::master_idx_t               owner;      // Master whose transfer is running
    bus_arb_pkg::slave_idx_t                sel;
    logic [bus_arb_pkg::slave_nib_w-1:0]    nib;
    logic                                   decode_ok;
    logic                                   pready_sel;
    bus_arb_pkg::data_t                     prdata_sel;

    assign nib = start_addr[bus_arb_pkg::slave_lsb +: bus_arb_pkg::slave_nib_w];

    // Region must match and the nibble must name an existing slave
    assign decode_ok = (start_addr[bus_arb_pkg::addr_w-1:bus_arb_pkg::addr_w/2] ==
                        bus_arb_pkg::region_base) &&
                       (nib < bus_arb_pkg::slave_nib_w'(bus_arb_pkg::num_slaves));

    assign pready_sel = pready[sel];
    assign prdata_sel = prdata[sel];

    always_ff @(posedge bm0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= st_idle;
        end
        else
        begin
            case (state)
                st_idle:    if (start) state <= decode_ok ? st_setup : st_decline;
                st_setup:   state <= st_access;
                st_access:  if (pready_sel) state <= st_done;   // Wait states hold us here
                st_decline: state <= st_fail;
                default:    state <= st_idle;
            endcase
        end
    end

    // Transfer payload is captured at the pick and held until completion
    always_ff @(posedge bm0)
    begin
        if (state == st_idle && start)
        begin
            owner  <= winner;
            sel    <= nib[$bits(bus_arb_pkg::slave_idx_t)-1:0];
            paddr  <= start_addr;
            pwrite <= start_write;
            pwdata <= start_wdata;
        end
        if (state == st_access && pready_sel)
        begin
            rdata <= pwrite ? '0 : prdata_sel;
        end
        else if (state == st_decline)
        begin
            rdata <= '0;
        end
    end

    assign busy      = (state != st_idle);
    assign penable   = (state == st_access);
    assign xfer_done = (state == st_done) || (state == st_fail);
    assign err       = (state == st_fail);

    always_comb
    begin
        psel = '0;
        if (state == st_setup || state == st_access)
        begin
            psel[sel] = 1'b1;
        end
    end

    always_comb
    begin
        done = '0;
        if (xfer_done)
        begin
            done[owner] = 1'b1;     // Only the owning master sees the completion
        end
    end

endmodule : apb_bridge

`default_nettype wire

/* arbiter/bid_select.sv */
// Arbitration stage. Picks one requesting master per idle bus, holds its grant
// and hands the winner's transfer to the APB bridge.
`timescale 1ns/100ps
`default_nettype none

module bid_select (
    input  wire logic                                bm0,
    input  wire logic                                rst_n,
    input  wire logic [bus_arb_pkg::num_masters-1:0] req,
    input  wire bus_arb_pkg::bid_t                   bid     [bus_arb_pkg::num_masters],
    input  wire bus_arb_pkg::addr_t                  addr    [bus_arb_pkg::num_masters],
    input  wire logic [bus_arb_pkg::num_masters-1:0] write,
    input  wire bus_arb_pkg::data_t                  wdata   [bus_arb_pkg::num_masters],
    input  wire bus_arb_pkg::bid_t                   balance [bus_arb_pkg::num_masters],
    input  wire logic                                busy,   // Bridge still owns the bus
    output logic                                     pick,
    output bus_arb_pkg::master_idx_t                 winner,
    output bus_arb_pkg::bid_t                        debit,
    output logic [bus_arb_pkg::num_masters-1:0]      grant,
    output logic                                     start,
    output bus_arb_pkg::addr_t                       start_addr,
    output logic                                     start_write,
    output bus_arb_pkg::data_t                       start_wdata
);

    bus_arb_pkg::wait_cnt_t   wait_cnt [bus_arb_pkg::num_masters];  // Picks lost in a row
    logic                     starve_hit;
    bus_arb_pkg::master_idx_t starve_idx;
    logic                     afford_hit;
    bus_arb_pkg::master_idx_t best_idx;
    bus_arb_pkg::bid_t        best_bid;
    bus_arb_pkg::master_idx_t first_idx;     // Lowest-index requester, for the broke case

    // Scan all requesters once for each of the three rules
    always_comb
    begin
        starve_hit = 1'b0;
        starve_idx = '0;
        first_idx  = '0;
        for (int i = bus_arb_pkg::num_masters - 1; i >= 0; i--)
        begin
            if (req[i])
            begin
                first_idx = bus_arb_pkg::master_idx_t'(i);  // Downward scan leaves the lowest
            end
            if (req[i] && wait_cnt[i] >= bus_arb_pkg::starve_limit)
            begin
                starve_hit = 1'b1;
                starve_idx = bus_arb_pkg::master_idx_t'(i);
            end
        end

        afford_hit = 1'b0;
        best_idx   = '0;
        best_bid   = '0;
        for (int i = 0; i < bus_arb_pkg::num_masters; i++)
        begin
            // Strictly greater keeps ties with the lower index
            if (req[i] && balance[i] >= bid[i] && (!afford_hit || bid[i] > best_bid))
            begin
                afford_hit = 1'b1;
                best_idx   = bus_arb_pkg::master_idx_t'(i);
                best_bid   = bid[i];
            end
        end

        if (starve_hit)
        begin
            winner = starve_idx;
            debit  = bid[starve_idx];
        end
        else if (afford_hit)
        begin
            winner = best_idx;
            debit  = best_bid;
        end
        else
        begin
            winner = first_idx;
            debit  = '0;        // Nobody can pay, so the bus is given away free
        end
    end

    // A pick happens on any edge with an idle bus and a pending request
    assign pick  = !busy && (|req);
    assign start = pick;

    assign start_addr  = addr[winner];
    assign start_write = write[winner];
    assign start_wdata = wdata[winner];

    always_ff @(posedge bm0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            grant <= '0;
        end
        else if (!busy)
        begin
            grant <= '0;                            // Released once the done cycle has passed
            if (pick)
            begin
                grant[winner] <= 1'b1;
            end
        end
    end

    always_ff @(posedge bm0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < bus_arb_pkg::num_masters; i++)
            begin
                wait_cnt[i] <= '0;
            end
        end
        else if (pick)
        begin
            for (int i = 0; i < bus_arb_pkg::num_masters; i++)
            begin
                if (winner == bus_arb_pkg::master_idx_t'(i))
                begin
                    wait_cnt[i] <= '0;
                end
                else if (req[i] && wait_cnt[i] != '1)
                begin
                    wait_cnt[i] <= wait_cnt[i] + 1'b1;  // Saturates at all ones
                end
            end
        end
    end

endmodule : bid_select

`default_nettype wire

/* arbiter/credit_ledger.sv */
// Credit balances for every master.
// A pick debits the winner, and every few completed transfers all balances are topped up.
`timescale 1ns/100ps
`default_nettype none

module credit_ledger (
    input  wire logic                      bm0,
    input  wire logic                      rst_n,
    input  wire logic                      pick,       // One-cycle pulse when a winner is chosen
    input  wire bus_arb_pkg::master_idx_t  winner,
    input  wire bus_arb_pkg::bid_t         debit,      // Amount taken from the winner
    input  wire logic                      xfer_done,  // One pulse per completed transfer
    output bus_arb_pkg::bid_t              balance [bus_arb_pkg::num_masters]
);

    bus_arb_pkg::bid_t             next_bal [bus_arb_pkg::num_masters];
    logic [bus_arb_pkg::cnt_w-1:0] xfer_cnt;    // Completed transfers since the last refill
    logic                          refill;

    // The last transfer of each group of refill_every triggers the refill
    assign refill = xfer_done && (xfer_cnt == bus_arb_pkg::refill_every - 1'b1);

    always_comb
    begin : next_balance
        logic [bus_arb_pkg::bid_w:0] sum;   // One extra bit so the refill cannot wrap
        for (int i = 0; i < bus_arb_pkg::num_masters; i++)
        begin
            next_bal[i] = balance[i];
            if (pick && winner == bus_arb_pkg::master_idx_t'(i))
            begin
                // A debit larger than the balance leaves the master broke
                next_bal[i] = (balance[i] > debit) ? balance[i] - debit : '0;
            end
            sum = {1'b0, next_bal[i]} + {1'b0, bus_arb_pkg::refill_amount};
            if (refill)
            begin
                next_bal[i] = (sum > {1'b0, bus_arb_pkg::balance_max}) ?
                              bus_arb_pkg::balance_max : sum[bus_arb_pkg::bid_w-1:0];
            end
        end
    end

    always_ff @(posedge bm0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            xfer_cnt <= '0;
        end
        else if (xfer_done)
        begin
            xfer_cnt <= refill ? '0 : xfer_cnt + 1'b1;  // Wrap back after each refill
        end
    end

    always_ff @(posedge bm0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < bus_arb_pkg::num_masters; i++)
            begin
                balance[i] <= bus_arb_pkg::balance_max;     // Every master starts full
            end
        end
        else
        begin
            for (int i = 0; i < bus_arb_pkg::num_masters; i++)
            begin
                balance[i] <= next_bal[i];
            end
        end
    end

endmodule : credit_ledger

`default_nettype wire

/* common/bus_arb_pkg.sv */
// Shared widths, types and arbitration constants for the credit-based bus arbiter.
// RTL and testbench refer to these by package-scoped names.
`default_nettype none

package bus_arb_pkg;

    // Bus geometry
    localparam int num_masters = 4;                 // Masters bidding for the bus
    localparam int num_slaves  = 4;                 // APB slaves behind the bridge
    localparam int addr_w      = 32;                // Address width
    localparam int data_w      = 32;                // Data width

    // Arbitration widths
    localparam int bid_w  = 8;                      // Bids and balances share this width
    localparam int wait_w = 3;                      // Starvation counter width
    localparam int cnt_w  = 3;                      // Counts completed transfers toward a refill

    typedef logic [$clog2(num_masters)-1:0] master_idx_t;
    typedef logic [$clog2(num_slaves)-1:0]  slave_idx_t;
    typedef logic [addr_w-1:0]              addr_t;
    typedef logic [data_w-1:0]              data_t;
    typedef logic [bid_w-1:0]               bid_t;
    typedef logic [wait_w-1:0]              wait_cnt_t;

    // Credit policy
    localparam bid_t balance_max   = bid_t'(200);  // Reset value and refill ceiling
    localparam bid_t refill_amount = bid_t'(40);   // Added to every balance on refill

    // A refill happens on every refill_every-th completed transfer
    localparam logic [cnt_w-1:0] refill_every = cnt_w'(4);

    // Lost picks after which a waiting requester is forced through
    localparam wait_cnt_t starve_limit = wait_cnt_t'(3);

    // Address map: upper half selects the region, one nibble selects the slave
    localparam logic [addr_w/2-1:0] region_base = 16'hFFEF;
    localparam int slave_lsb   = 12;                // Lowest bit of the slave nibble
    localparam int slave_nib_w = 4;                 // Width of the slave nibble

endpackage : bus_arb_pkg

`default_nettype wire
